/* vlog.f */
common/harnessPkg.sv
design/panelSampler.sv
control/runControl.sv
design/eventCounter.sv
display/pageSelect.sv
display/segScanner.sv
design/benchTop.sv
test/benchTop_chk.sv
test/benchTop_tb.sv

/* Makefile */
TOP := benchTop_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* test/benchTop_tb.sv */
`timescale 1ns/1ps

module benchTop_tb
   import harnessPkg::*;
();

   localparam int clkPeriod     = 4;
   localparam int resetCycles   = 8;
   localparam int frameCycles   = numDigits * digitCycles;
   // Sampling plus up to two frames until a new word is on the digits
   localparam int settleCycles  = 3 * frameCycles + 4;
   localparam int displayCycles = settleCycles + frameCycles;
   localparam int stepCycles    = 10;
   localparam int runCycles     = 80;
   localparam int clearCycles   = 40;
   localparam int testCycles    = resetCycles + 4 * displayCycles + 9 * stepCycles
                                  + 3 * runCycles + 2 * clearCycles;
   localparam int timeoutCycles = testCycles + 200;

   localparam panelButtonsT centreBtn = '{centre: 1'b1, up: 1'b0, right: 1'b0};
   localparam panelButtonsT upBtn     = '{centre: 1'b0, up: 1'b1, right: 1'b0};

   logic        f100Hz;
   logic        res;
   panelInT     panel;
   logic [15:0] leds;
   logic [7:0]  seg;
   logic [7:0]  an;

   int          errors;
   int unsigned lcgState;
   int          modelCount;

   benchTop DUT (
      .f100Hz (f100Hz),
      .res    (res),
      .panel  (panel),
      .leds   (leds),
      .seg    (seg),
      .an     (an)
   );

   always #(clkPeriod / 2) f100Hz = ~f100Hz;

   ////////////////////////////////
   // Helpers
   ////////////////////////////////

   function automatic int unsigned nextRandom();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState >> 16;
   endfunction

   // Usual gfedcba patterns with lit segments high
   function automatic int segToHex(input logic [6:0] lit);
      case (lit)
         7'h3F: return 0;
         7'h06: return 1;
         7'h5B: return 2;
         7'h4F: return 3;
         7'h66: return 4;
         7'h6D: return 5;
         7'h7D: return 6;
         7'h07: return 7;
         7'h7F: return 8;
         7'h6F: return 9;
         7'h77: return 10;
         7'h7C: return 11;
         7'h39: return 12;
         7'h5E: return 13;
         7'h79: return 14;
         7'h71: return 15;
         default: return -1;
      endcase
   endfunction

   task automatic logError(input string msg);
      errors++;
      $display("** Error at %0d ns: %s", $time, msg);
   endtask

   task automatic checkLeds(input string what);
      assert (leds == modelCount[15:0])
      else
         logError($sformatf("%s: leds %h, expected %h", what, leds, modelCount[15:0]));
   endtask

   // Rate on 15..12, page on 7..4, random filler elsewhere
   task automatic setSwitches(input logic [3:0] rate, input logic [3:0] page);
      logic [7:0] other;
      other = 8'(nextRandom());
      panel.switches = {rate, other[7:4], page, other[3:0]};
      repeat (4) @(negedge f100Hz);
   endtask

   task automatic pressButtons(input panelButtonsT mask);
      int unsigned hold;
      hold = 1 + nextRandom() % 3;
      panel.buttons = mask;
      repeat (hold) @(negedge f100Hz);
      panel.buttons = '0;
      repeat (6) @(negedge f100Hz);
   endtask

   // Count moves 4 edges after the edge that samples the press
   task automatic stepCheck();
      int unsigned hold;
      int          e;
      hold = 1 + nextRandom() % 4;
      panel.buttons.right = 1'b1;
      for (e = 1; e <= 5; e++)
      begin
         @(negedge f100Hz);
         if (e == hold)
            panel.buttons.right = 1'b0;
         if (e == 5)
            modelCount++;
         checkLeds("step");
      end
      panel.buttons.right = 1'b0;
      repeat (4) @(negedge f100Hz);
   endtask

   // Running at rate 1 from edge 4 to edge 49 gives a tick every 10 edges
   task automatic runCheck();
      int unsigned hold;
      int          base;
      int          e;
      hold = 1 + nextRandom() % 3;
      base = modelCount;
      panel.buttons.centre = 1'b1;
      for (e = 1; e <= 70; e++)
      begin
         @(negedge f100Hz);
         if (e == hold || e == 45 + hold)
            panel.buttons.centre = 1'b0;
         else if (e == 45)
            panel.buttons.centre = 1'b1;
         if (e >= 4)
            modelCount = base + ((e < 49 ? e : 49) - 4) / 10;
         checkLeds("run at rate 1");
      end
   endtask

   // With rate 1 selected a running machine would tick inside the window
   task automatic clearCheck(input string where);
      pressButtons(upBtn);
      modelCount = 0;
      repeat (15)
      begin
         checkLeds(where);
         @(negedge f100Hz);
      end
   endtask

   task automatic checkDisplay(input logic [31:0] expected, input string page);
      logic [31:0] shown;
      logic [7:0]  seen;
      int          digit;
      int          i;
      shown = '0;
      seen  = '0;
      repeat (settleCycles) @(negedge f100Hz);
      repeat (frameCycles)
      begin
         @(negedge f100Hz);
         for (i = 0; i < numDigits; i++)
         begin
            if (!an[i])
            begin
               digit = segToHex(~seg[6:0]);
               assert (digit >= 0 && seg[7])
               else
                  logError($sformatf("%s: bad segment pattern %h", page, seg));
               shown[4*i +: 4] = 4'(digit);
               seen[i]         = 1'b1;
            end
         end
      end
      assert (seen == 8'hFF)
      else
         logError($sformatf("%s: digits %b never lit during a frame", page, ~seen));
      assert (shown == expected)
      else
         logError($sformatf("%s: display %h, expected %h", page, shown, expected));
   endtask

   ////////////////////////////////
   // Test sequence
   ////////////////////////////////

   initial
   begin
      errors     = 0;
      lcgState   = 86;
      modelCount = 0;
      f100Hz     = 1'b0;
      res        = 1'b1;
      panel      = '0;
      repeat (resetCycles) @(negedge f100Hz);
      res = 1'b0;

      checkLeds("after reset");
      assert (an == 8'hFF && seg == 8'hFF)
      else
         logError($sformatf("anodes %b segments %b active before the first word", an, seg));
      // Rate 3 in digit 1, stopped state in digit 0
      setSwitches(4'd3, pageStatus);
      checkDisplay({24'd0, 4'd3, 4'(stStopped)}, "status page");

      repeat (3) stepCheck();

      setSwitches(4'd1, pageCounter);
      runCheck();
      setSwitches(4'd5, pageCounter);
      pressButtons(centreBtn);
      repeat (40)
      begin
         @(negedge f100Hz);
         checkLeds("run at rate 5");
      end
      pressButtons(centreBtn);

      setSwitches(4'd1, pageCounter);
      repeat (2) stepCheck();
      clearCheck("clear when stopped");
      pressButtons(centreBtn);
      repeat (25) @(negedge f100Hz);
      clearCheck("clear when running");

      setSwitches(4'd0, pageSwitches);
      checkDisplay({16'd0, panel.switches}, "switch page");
      repeat (3) stepCheck();
      setSwitches(4'd0, pageCounter);
      checkDisplay(modelCount, "counter page");
      setSwitches(4'd0, 4'hB);
      checkDisplay(32'd0, "unused page");

      $display("Checks done: %0d testbench errors, %0d bound assertion failures",
               errors, DUT.uChk.failCount);
      if (errors == 0 && DUT.uChk.failCount == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   // Watchdog sized from the test budget
   initial
   begin
      #(timeoutCycles * clkPeriod);
      $display("Watchdog: tests did not finish within %0d cycles", timeoutCycles);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* test/benchTop_chk.sv */
`timescale 1ns/1ps

module benchTopChk
   import harnessPkg::*;
(
   input logic        f100Hz,
   input logic        res,
   input logic [15:0] leds,
   input logic [7:0]  an,
   input displayWordT word,
   input logic        wordValid,
   input logic        wordReady
);

   int failCount = 0;

   // At most one digit driven
   anodeOneHot: assert property (@(posedge f100Hz) disable iff (res)
      (an == 8'hFF) || $onehot(~an))
   else
   begin
      failCount++;
      $error("anodes %b drive more than one digit", an);
   end

   ledsStep: assert property (@(posedge f100Hz) disable iff (res)
      (leds == $past(leds)) || (leds == $past(leds) + 16'd1) || (leds == 16'd0))
   else
   begin
      failCount++;
      $error("leds jumped from %h to %h", $past(leds), leds);
   end

   ////////////////////////////////
   // Page to scanner handshake
   ////////////////////////////////

   validHeld: assert property (@(posedge f100Hz) disable iff (res)
      wordValid && !wordReady |=> wordValid)
   else
   begin
      failCount++;
      $error("wordValid dropped before wordReady");
   end

   wordStable: assert property (@(posedge f100Hz) disable iff (res)
      wordValid && !wordReady |=> $stable(word))
   else
   begin
      failCount++;
      $error("word changed under back-pressure");
   end

endmodule

bind benchTop benchTopChk uChk (
   .f100Hz    (f100Hz),
   .res       (res),
   .leds      (leds),
   .an        (an),
   .word      (word),
   .wordValid (wordValid),
   .wordReady (wordReady)
);

/* design/benchTop.sv */
`timescale 1ns/1ps

module benchTop
   import harnessPkg::*;
(
   input  logic        f100Hz,
   input  logic        res,
   input  panelInT     panel,
   output logic [15:0] leds,
   output logic [7:0]  seg,
   output logic [7:0]  an
);

   panelInT                 sampled;
   panelButtonsT            pressed;
   runStateT                state;
   logic                    countEnable;
   logic                    stepPulse;
   logic                    clearPulse;
   logic [counterWidth-1:0] count;
   displayWordT             word;
   logic                    wordValid;
   logic                    wordReady;

   //////////////////////////////
   // Panel input and control
   //////////////////////////////

   panelSampler uSampler (
      .f100Hz  (f100Hz),
      .res     (res),
      .panel   (panel),
      .sampled (sampled),
      .pressed (pressed)
   );

   runControl uControl (
      .f100Hz      (f100Hz),
      .res         (res),
      .pressed     (pressed),
      .state       (state),
      .countEnable (countEnable),
      .stepPulse   (stepPulse),
      .clearPulse  (clearPulse)
   );

   // Rate code on switches 15..12
   eventCounter uCounter (
      .f100Hz      (f100Hz),
      .res         (res),
      .rateCode    (sampled.switches[15:12]),
      .countEnable (countEnable),
      .stepPulse   (stepPulse),
      .clearPulse  (clearPulse),
      .count       (count)
   );

   //////////////////////////////
   // Display path
   //////////////////////////////

   // Page code on switches 7..4
   pageSelect uPage (
      .f100Hz    (f100Hz),
      .res       (res),
      .pageCode  (sampled.switches[7:4]),
      .count     (count),
      .switches  (sampled.switches),
      .state     (state),
      .rateCode  (sampled.switches[15:12]),
      .word      (word),
      .wordValid (wordValid),
      .wordReady (wordReady)
   );

   segScanner uScanner (
      .f100Hz    (f100Hz),
      .res       (res),
      .word      (word),
      .wordValid (wordValid),
      .wordReady (wordReady),
      .seg       (seg),
      .an        (an)
   );

   assign leds = count[15:0];

endmodule

/* display/segScanner.sv */
`timescale 1ns/1ps

module segScanner
   import harnessPkg::*;
(
   input  logic        f100Hz,
   input  logic        res,
   input  displayWordT word,
   input  logic        wordValid,
   output logic        wordReady,
   output logic [7:0]  seg,
   output logic [7:0]  an
);

   displayWordT              frameBuf;
   logic                     loaded;
   logic [phaseWidth-1:0]    phase;
   logic [digitIdxWidth-1:0] digitIdx;
   logic                     frameEnd;
   logic                     accept;
   logic [3:0]               hexVal;
   logic [6:0]               segOn;

   //////////////////////////////
   // Frame timing
   //////////////////////////////

   assign frameEnd  = (phase == phaseWidth'(digitCycles - 1)) &&
                      (digitIdx == digitIdxWidth'(numDigits - 1));
   // Ready until the first word, then once per frame
   assign wordReady = !loaded || frameEnd;
   assign accept    = wordReady && wordValid;

   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         loaded   <= 1'b0;
         phase    <= '0;
         digitIdx <= '0;
      end
      else if (accept)
      begin
         // New frame starts right after the accept
         loaded   <= 1'b1;
         phase    <= '0;
         digitIdx <= '0;
      end
      else if (phase == phaseWidth'(digitCycles - 1))
      begin
         phase    <= '0;
         digitIdx <= digitIdx + 1'b1;
      end
      else
      begin
         phase <= phase + 1'b1;
      end
   end

   always_ff @(posedge f100Hz)
   begin
      if (accept)
         frameBuf <= word;
   end

   //////////////////////////////
   // Hex decode, gfedcba
   //////////////////////////////

   assign hexVal = frameBuf.digit[digitIdx];

   always_comb
   begin
      case (hexVal)
         4'h0: segOn = 7'h3F;
         4'h1: segOn = 7'h06;
         4'h2: segOn = 7'h5B;
         4'h3: segOn = 7'h4F;
         4'h4: segOn = 7'h66;
         4'h5: segOn = 7'h6D;
         4'h6: segOn = 7'h7D;
         4'h7: segOn = 7'h07;
         4'h8: segOn = 7'h7F;
         4'h9: segOn = 7'h6F;
         4'hA: segOn = 7'h77;
         4'hB: segOn = 7'h7C;
         4'hC: segOn = 7'h39;
         4'hD: segOn = 7'h5E;
         4'hE: segOn = 7'h79;
         default: segOn = 7'h71;
      endcase
   end

   // Active low outputs, blank before the first word, dp off
   assign seg = loaded ? {1'b1, ~segOn} : 8'hFF;
   assign an  = loaded ? ~(8'h01 << digitIdx) : 8'hFF;

endmodule

/* display/pageSelect.sv */
`timescale 1ns/1ps

module pageSelect
   import harnessPkg::*;
(
   input  logic                    f100Hz,
   input  logic                    res,
   input  logic [3:0]              pageCode,
   input  logic [counterWidth-1:0] count,
   input  logic [15:0]             switches,
   input  runStateT                state,
   input  logic [3:0]              rateCode,
   output displayWordT             word,
   output logic                    wordValid,
   input  logic                    wordReady
);

   displayWordT nextWord;
   logic        load;

   //////////////////////////////
   // Page mux
   //////////////////////////////

   always_comb
   begin
      case (pageCode)
         pageCounter:  nextWord.whole = count;
         pageSwitches: nextWord.whole = {16'd0, switches};
         // State in digit 0, rate in digit 1
         pageStatus:   nextWord.whole = {24'd0, rateCode, 2'b00, state};
         default:      nextWord.whole = 32'd0;
      endcase
   end

   // Empty register or transfer this cycle
   assign load = !wordValid || wordReady;

   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
         wordValid <= 1'b0;
      else if (load)
         wordValid <= 1'b1;
   end

   always_ff @(posedge f100Hz)
   begin
      if (load)
         word <= nextWord;
   end

endmodule

/* design/eventCounter.sv */
`timescale 1ns/1ps

module eventCounter
   import harnessPkg::*;
(
   input  logic                    f100Hz,
   input  logic                    res,
   input  logic [3:0]              rateCode,
   input  logic                    countEnable,
   input  logic                    stepPulse,
   input  logic                    clearPulse,
   output logic [counterWidth-1:0] count
);

   logic [9:0] prescale;
   logic [9:0] prescaleLast;
   logic [3:0] lastRate;
   logic       rateChange;
   logic       rateOk;
   logic       tick;

   // Terminal prescaler value per decade
   always_comb
   begin
      case (rateCode)
         4'd0:    prescaleLast = 10'd0;
         4'd1:    prescaleLast = 10'd9;
         4'd2:    prescaleLast = 10'd99;
         4'd3:    prescaleLast = 10'd999;
         default: prescaleLast = 10'd0;
      endcase
   end

   assign rateChange = (rateCode != lastRate);
   assign rateOk     = (rateCode <= maxRateCode);
   assign tick       = countEnable && rateOk && !rateChange && (prescale == prescaleLast);

   //////////////////////////////
   // Prescaler and counter
   //////////////////////////////

   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         lastRate <= '0;
         prescale <= '0;
         count    <= '0;
      end
      else
      begin
         lastRate <= rateCode;
         // Restart on clear, rate change, stop, or after each tick
         if (clearPulse || rateChange || !countEnable || !rateOk || tick)
            prescale <= '0;
         else
            prescale <= prescale + 10'd1;

         if (clearPulse)
            count <= '0;
         else if (stepPulse || tick)
            count <= count + 1'b1;
      end
   end

endmodule

/* control/runControl.sv */
`timescale 1ns/1ps

module runControl
   import harnessPkg::*;
(
   input  logic         f100Hz,
   input  logic         res,
   input  panelButtonsT pressed,
   output runStateT     state,
   output logic         countEnable,
   output logic         stepPulse,
   output logic         clearPulse
);

   runStateT nextState;

   //////////////////////////////
   // Next state
   //////////////////////////////

   always_comb
   begin
      nextState = state;
      // Clear wins over everything
      if (pressed.up)
      begin
         nextState = stClear;
      end
      else
      begin
         case (state)
            stStopped:
            begin
               if (pressed.right)
                  nextState = stStep;
               else if (pressed.centre)
                  nextState = stRunning;
            end
            stRunning:
            begin
               if (pressed.centre)
                  nextState = stStopped;
            end
            // Step and clear last one cycle
            stStep:  nextState = stStopped;
            stClear: nextState = stStopped;
            default: nextState = stStopped;
         endcase
      end
   end

   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
         state <= stStopped;
      else
         state <= nextState;
   end

   //////////////////////////////
   // Outputs from state only
   //////////////////////////////

   assign countEnable = (state == stRunning);
   assign stepPulse   = (state == stStep);
   assign clearPulse  = (state == stClear);

endmodule

/* design/panelSampler.sv */
`timescale 1ns/1ps

module panelSampler
   import harnessPkg::*;
(
   input  logic         f100Hz,
   input  logic         res,
   input  panelInT      panel,
   output panelInT      sampled,
   output panelButtonsT pressed
);

   panelInT      stage1;
   panelInT      stage2;
   panelButtonsT stage3;

   //////////////////////////////
   // Two-flop synchroniser
   //////////////////////////////

   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         stage1 <= '0;
         stage2 <= '0;
      end
      else
      begin
         stage1 <= panel;
         stage2 <= stage1;
      end
   end

   assign sampled = stage2;

   // Edge detect on the buttons, one pulse per press
   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         stage3  <= '0;
         pressed <= '0;
      end
      else
      begin
         stage3  <= stage2.buttons;
         pressed <= stage2.buttons & ~stage3;
      end
   end

endmodule

/* common/harnessPkg.sv */
package harnessPkg;

   //////////////////////////////
   // Sizes
   //////////////////////////////

   localparam int numDigits     = 8;
   localparam int digitCycles   = 2;
   localparam int counterWidth  = 32;
   localparam int maxRateCode   = 3;

   // Scanner counter widths
   localparam int phaseWidth    = $clog2(digitCycles);
   localparam int digitIdxWidth = $clog2(numDigits);

   // Display page codes, anything else shows zero
   localparam logic [3:0] pageCounter  = 4'd0;
   localparam logic [3:0] pageSwitches = 4'd1;
   localparam logic [3:0] pageStatus   = 4'd2;

   //////////////////////////////
   // Types
   //////////////////////////////

   typedef enum logic [1:0] {
      stStopped = 2'd0,
      stRunning = 2'd1,
      stStep    = 2'd2,
      stClear   = 2'd3
   } runStateT;

   typedef struct packed {
      logic centre;
      logic up;
      logic right;
   } panelButtonsT;

   typedef struct packed {
      logic [15:0]  switches;
      panelButtonsT buttons;
   } panelInT;

   // Digit 0 is the least significant nibble
   typedef union packed {
      logic [31:0]                whole;
      logic [numDigits-1:0][3:0] digit;
   } displayWordT;

endpackage
